//--- hw/procci_bus_pkg.sv
package procci_bus_pkg;

    localparam int ADDR_W           = 8;   // Word address, both memories
    localparam int DATA_W           = 32;
    localparam int MEM_WORDS        = 256;
    localparam int RESET_CLK_CYCLES = 8;   // Core reset hold after run rises
    localparam int RST_CNT_W        = $clog2(RESET_CLK_CYCLES + 1);

    // One Wishbone-classic master request
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } wb_req_t;

    // Slave response, ack is a single-cycle pulse
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ack;
    } wb_rsp_t;

    // Host access to either memory
    typedef struct packed {
        logic              valid;   // One-cycle strobe
        logic              we;
        logic              mem_sel; // 0 imem, 1 dmem
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

endpackage

//--- hw/procci_isa_pkg.sv
package procci_isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_LOAD  = 4'h1,
        OP_STORE = 4'h2,
        OP_ADD   = 4'h3,
        OP_ADDI  = 4'h4,
        OP_JNZ   = 4'h5,
        OP_HALT  = 4'h6
    } opcode_e;

    // LOAD, STORE, ADD, and JNZ with addr as jump target
    typedef struct packed {
        opcode_e     opcode;
        logic [19:0] rsvd;
        logic [7:0]  addr;
    } mem_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] rsvd;
        logic [15:0] imm;     // Signed, widened by sext_imm
    } imm_fmt_t;

    typedef union packed {
        mem_fmt_t mem_fmt;
        imm_fmt_t imm_fmt;
    } instr_u;

    function automatic logic [31:0] sext_imm(instr_u w);
        return {{16{w.imm_fmt.imm[15]}}, w.imm_fmt.imm};
    endfunction

    function automatic instr_u enc_mem(opcode_e op, logic [7:0] addr);
        instr_u w;
        w = '0;
        w.mem_fmt.opcode = op;
        w.mem_fmt.addr = addr;
        return w;
    endfunction

    function automatic instr_u enc_imm(opcode_e op, logic [15:0] imm);
        instr_u w;
        w = '0;
        w.imm_fmt.opcode = op;
        w.imm_fmt.imm = imm;
        return w;
    endfunction

endpackage

//--- hw/wb_memory.sv
module wb_memory (
    input  logic                    clk,
    input  logic                    reset_i,
    input  procci_bus_pkg::wb_req_t req_i,
    output procci_bus_pkg::wb_rsp_t rsp_o
);
    import procci_bus_pkg::*;

    logic [DATA_W-1:0] mem_q [MEM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic              ack_q;
    logic              access;

    // First cycle of a request only, the ack cycle is not a new access
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end
            // Writes echo the new word back
            rdata_q <= req_i.we ? req_i.wdata : mem_q[req_i.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = ack_q;

    a_ack_single: assert property (
        @(posedge clk) disable iff (reset_i)
        rsp_o.ack |=> !rsp_o.ack
    ) else $error("wb_memory: ack held for two cycles");

endmodule

//--- hw/controller.sv
module controller (
    input  logic                              clk,
    input  logic                              reset_i,
    input  procci_bus_pkg::host_req_t         host_req_i,
    input  logic                              host_run_i,
    output logic [procci_bus_pkg::DATA_W-1:0] host_rdata_o,
    output logic                              host_ack_o,
    output logic                              core_rst_o,
    input  procci_bus_pkg::wb_req_t           imem_req_i,
    output procci_bus_pkg::wb_rsp_t           imem_rsp_o,
    input  procci_bus_pkg::wb_req_t           dmem_req_i,
    output procci_bus_pkg::wb_rsp_t           dmem_rsp_o
);
    import procci_bus_pkg::*;

    logic [RST_CNT_W-1:0] rst_cnt_q;
    logic                 core_rst_q;
    host_req_t            host_q;
    logic                 host_pend_q;   // Host access outstanding
    logic                 host_accept;
    logic                 host_mem_ack;
    wb_req_t              host_wb_req;
    wb_req_t              imem_mem_req;
    wb_req_t              dmem_mem_req;

    // Core reset sequencing
    always_ff @(posedge clk) begin
        if (reset_i || !host_run_i) begin
            rst_cnt_q  <= '0;
            core_rst_q <= 1'b1;
        end else if (core_rst_q) begin
            rst_cnt_q <= rst_cnt_q + 1'b1;
            if (rst_cnt_q == RST_CNT_W'(RESET_CLK_CYCLES - 1)) begin
                core_rst_q <= 1'b0; // Release on the Nth cycle of run
            end
        end
    end

    assign core_rst_o = core_rst_q;

    // Strobes arriving while the core runs are dropped
    assign host_accept = host_req_i.valid && core_rst_q && !host_pend_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_pend_q <= 1'b0;
        end else if (host_accept) begin
            host_pend_q <= 1'b1;
        end else if (host_pend_q && host_mem_ack) begin
            host_pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (host_accept) begin
            host_q <= host_req_i;
        end
    end

    assign host_mem_ack = host_q.mem_sel ? dmem_rsp_o.ack : imem_rsp_o.ack;

    // Request stays up for a single cycle, the memory acks the next one
    always_comb begin
        host_wb_req.cyc   = host_pend_q && !host_mem_ack;
        host_wb_req.stb   = host_wb_req.cyc;
        host_wb_req.we    = host_q.we;
        host_wb_req.addr  = host_q.addr;
        host_wb_req.wdata = host_q.wdata;
    end

    // Host owns both memories while the core is held in reset
    always_comb begin
        imem_mem_req = imem_req_i;
        dmem_mem_req = dmem_req_i;
        if (core_rst_q) begin
            imem_mem_req = (host_pend_q && !host_q.mem_sel) ? host_wb_req : '0;
            dmem_mem_req = (host_pend_q && host_q.mem_sel) ? host_wb_req : '0;
        end
    end

    assign host_ack_o   = host_pend_q && host_mem_ack;
    assign host_rdata_o = host_q.mem_sel ? dmem_rsp_o.rdata : imem_rsp_o.rdata;

    wb_memory u_imem (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (imem_mem_req),
        .rsp_o   (imem_rsp_o)
    );

    wb_memory u_dmem (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (dmem_mem_req),
        .rsp_o   (dmem_rsp_o)
    );

    a_no_host_at_release: assert property (
        @(posedge clk) disable iff (reset_i)
        $fell(core_rst_o) |-> !host_pend_q
    ) else $error("controller: core released with a host access pending");

endmodule

//--- hw/accum_core.sv
module accum_core (
    input  logic                    clk,
    input  logic                    rst_i,
    output procci_bus_pkg::wb_req_t imem_req_o,
    input  procci_bus_pkg::wb_rsp_t imem_rsp_i,
    output procci_bus_pkg::wb_req_t dmem_req_o,
    input  procci_bus_pkg::wb_rsp_t dmem_rsp_i,
    output logic                    halted_o
);
    import procci_bus_pkg::*;
    import procci_isa_pkg::*;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_DATA,
        ST_HALT
    } state_e;

    state_e            state_q;
    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] pc_next;
    logic [DATA_W-1:0] acc_q;
    instr_u            instr_q;
    opcode_e           op;
    wb_req_t           imem_q;
    wb_req_t           dmem_q;

    function automatic wb_req_t fetch_req(logic [ADDR_W-1:0] a);
        wb_req_t r;
        r      = '0;
        r.cyc  = 1'b1;
        r.stb  = 1'b1;
        r.addr = a;
        return r;
    endfunction

    assign op = instr_q.mem_fmt.opcode; // Opcode sits in the same bits of both views

    // PC wraps at 256 by width
    always_comb begin
        pc_next = pc_q + 1'b1;
        if (op == OP_JNZ && acc_q != '0) begin
            pc_next = instr_q.mem_fmt.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= ST_FETCH;
            pc_q       <= '0;
            acc_q      <= '0;
            imem_q.cyc <= 1'b0;
            imem_q.stb <= 1'b0;
            dmem_q.cyc <= 1'b0;
            dmem_q.stb <= 1'b0;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (!imem_q.cyc) begin
                        imem_q <= fetch_req(pc_q); // Only right after reset
                    end else if (imem_rsp_i.ack) begin
                        imem_q.cyc <= 1'b0;
                        imem_q.stb <= 1'b0;
                        instr_q    <= imem_rsp_i.rdata;
                        state_q    <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    case (op)
                        OP_LOAD, OP_ADD, OP_STORE: begin
                            dmem_q <= '{cyc: 1'b1, stb: 1'b1, we: (op == OP_STORE),
                                        addr: instr_q.mem_fmt.addr, wdata: acc_q};
                            state_q <= ST_DATA;
                        end
                        OP_HALT: state_q <= ST_HALT;
                        default: begin  // ADDI, JNZ, NOP and unknown
                            if (op == OP_ADDI) begin
                                acc_q <= acc_q + sext_imm(instr_q);
                            end
                            pc_q    <= pc_next;
                            imem_q  <= fetch_req(pc_next);
                            state_q <= ST_FETCH;
                        end
                    endcase
                end
                ST_DATA: begin
                    if (dmem_rsp_i.ack) begin
                        dmem_q.cyc <= 1'b0;
                        dmem_q.stb <= 1'b0;
                        if (op == OP_LOAD) begin
                            acc_q <= dmem_rsp_i.rdata;
                        end else if (op == OP_ADD) begin
                            acc_q <= acc_q + dmem_rsp_i.rdata;
                        end
                        pc_q    <= pc_next;
                        imem_q  <= fetch_req(pc_next); // Next fetch overlaps nothing
                        state_q <= ST_FETCH;
                    end
                end
                default: ;  // Halted until reset
            endcase
        end
    end

    assign imem_req_o = imem_q;
    assign dmem_req_o = dmem_q;
    assign halted_o   = (state_q == ST_HALT);

    a_imem_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (imem_req_o.stb && !imem_rsp_i.ack) |=> $stable(imem_req_o)
    ) else $error("accum_core: imem request changed before ack");

    a_dmem_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (dmem_req_o.stb && !dmem_rsp_i.ack) |=> $stable(dmem_req_o)
    ) else $error("accum_core: dmem request changed before ack");

endmodule

//--- hw/processorci_top.sv
module processorci_top (
    input  logic                              sys_clk,
    input  logic                              reset_i,
    input  procci_bus_pkg::host_req_t         host_req_i,
    input  logic                              host_run_i,
    output logic [procci_bus_pkg::DATA_W-1:0] host_rdata_o,
    output logic                              host_ack_o,
    output logic                              core_halted_o
);
    import procci_bus_pkg::*;

    logic    core_rst;
    wb_req_t imem_req;   // Instruction bus
    wb_rsp_t imem_rsp;
    wb_req_t dmem_req;   // Data bus
    wb_rsp_t dmem_rsp;

    controller u_controller (
        .clk          (sys_clk),
        .reset_i      (reset_i),
        .host_req_i   (host_req_i),
        .host_run_i   (host_run_i),
        .host_rdata_o (host_rdata_o),
        .host_ack_o   (host_ack_o),
        .core_rst_o   (core_rst),
        .imem_req_i   (imem_req),
        .imem_rsp_o   (imem_rsp),
        .dmem_req_i   (dmem_req),
        .dmem_rsp_o   (dmem_rsp)
    );

    // Core runs on the system clock
    accum_core u_core (
        .clk        (sys_clk),
        .rst_i      (core_rst),
        .imem_req_o (imem_req),
        .imem_rsp_i (imem_rsp),
        .dmem_req_o (dmem_req),
        .dmem_rsp_i (dmem_rsp),
        .halted_o   (core_halted_o)
    );

endmodule

//--- tb/tb_processorci_top.sv
module tb_processorci_top;
    timeunit 1ns;
    timeprecision 1ps;

    import procci_bus_pkg::*;
    import procci_isa_pkg::*;

    localparam int MAX_CYCLES = 4000; // Roughly twice what all five tests need
    localparam int N_RAND     = 24;

    logic              sys_clk = 1'b0;
    logic              reset_i;
    host_req_t         host_req;
    logic              host_run;
    logic [DATA_W-1:0] host_rdata;
    logic              host_ack;
    logic              core_halted;

    logic [DATA_W-1:0] imem_model [MEM_WORDS];
    logic [DATA_W-1:0] dmem_model [MEM_WORDS];
    logic [DATA_W-1:0] exp_rdata;
    logic [31:0]       rng_state = 32'd22294;
    logic [31:0]       prog [$];
    int                halt_cycle;
    int                run_cyc   = 0; // Cycles since host_run was first sampled high
    int                cycle_cnt = 0;
    int                err_cnt   = 0;
    int                test_errs = 0;
    int                pass_cnt  = 0;
    int                fail_cnt  = 0;

    processorci_top u_dut (
        .sys_clk       (sys_clk),
        .reset_i       (reset_i),
        .host_req_i    (host_req),
        .host_run_i    (host_run),
        .host_rdata_o  (host_rdata),
        .host_ack_o    (host_ack),
        .core_halted_o (core_halted)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        run_cyc   <= host_run ? run_cyc + 1 : 0;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles, the DUT never answered", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // Accepted strobe gives ack two cycles later, a dropped one gives none
    a_host_ack: assert property (
        @(posedge sys_clk) disable iff (reset_i)
        host_ack == ($past(host_req.valid, 2) && !$past(host_run, 2))
    ) else begin
        $display("[FAIL] %0t: host_ack_o is %0b, strobe two cycles back says otherwise",
                 $time, $sampled(host_ack));
        err_cnt++;
    end

    a_host_rdata: assert property (
        @(posedge sys_clk) disable iff (reset_i)
        host_ack |-> host_rdata == exp_rdata
    ) else begin
        $display("[FAIL] %0t: host_rdata_o is %h, expected %h",
                 $time, $sampled(host_rdata), $sampled(exp_rdata));
        err_cnt++;
    end

    // Halt shows up exactly at the cycle the model predicts, never before
    a_halt_timing: assert property (
        @(posedge sys_clk) disable iff (reset_i)
        host_run |-> core_halted == (run_cyc >= halt_cycle)
    ) else begin
        $display("[FAIL] %0t: core_halted_o is %0b at run cycle %0d, halt expected at %0d",
                 $time, $sampled(core_halted), $sampled(run_cyc), $sampled(halt_cycle));
        err_cnt++;
    end

    a_halt_clear: assert property (
        @(posedge sys_clk) disable iff (reset_i)
        (!host_run && !$past(host_run) && !$past(host_run, 2)) |-> !core_halted
    ) else begin
        $display("[FAIL] %0t: core_halted_o still high after host_run dropped", $time);
        err_cnt++;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Runs the program on the model memories, returns run_cyc of the first halted sample
    function automatic int run_model();
        logic [7:0]  pc;
        logic [31:0] acc;
        instr_u      w;
        int          cyc;
        int          step;
        pc  = '0;
        acc = '0;
        cyc = RESET_CLK_CYCLES + 1;     // Release plus the first request cycle
        for (step = 0; step < 1000; step++) begin
            w   = imem_model[pc];
            cyc = cyc + 3;              // Fetch and execute
            case (w.mem_fmt.opcode)
                OP_LOAD: begin
                    acc = dmem_model[w.mem_fmt.addr];
                    cyc = cyc + 2;
                end
                OP_ADD: begin
                    acc = acc + dmem_model[w.mem_fmt.addr];
                    cyc = cyc + 2;
                end
                OP_STORE: begin
                    dmem_model[w.mem_fmt.addr] = acc;
                    cyc = cyc + 2;
                end
                OP_ADDI: acc = acc + 32'($signed(w.imm_fmt.imm));
                OP_HALT: return cyc;
                default: ;
            endcase
            pc = (w.mem_fmt.opcode == OP_JNZ && acc != '0) ? w.mem_fmt.addr : pc + 8'd1;
        end
        return -1;
    endfunction

    task automatic host_access(input logic we, input logic sel, input logic [7:0] addr,
                               input logic [31:0] wdata);
        @(posedge sys_clk);
        #1;
        host_req = '{valid: 1'b1, we: we, mem_sel: sel, addr: addr, wdata: wdata};
        if (we && sel) begin
            dmem_model[addr] = wdata;
        end else if (we) begin
            imem_model[addr] = wdata;
        end
        exp_rdata = sel ? dmem_model[addr] : imem_model[addr];
        @(posedge sys_clk);
        #1;
        host_req.valid = 1'b0;
        while (!host_ack) begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    // Strobe while the core runs, the controller must ignore it
    task automatic host_dropped_write(input logic [7:0] addr, input logic [31:0] wdata);
        @(posedge sys_clk);
        #1;
        host_req = '{valid: 1'b1, we: 1'b1, mem_sel: 1'b1, addr: addr, wdata: wdata};
        @(posedge sys_clk);
        #1;
        host_req.valid = 1'b0;
        repeat (3) @(posedge sys_clk);
    endtask

    task automatic load_program();
        foreach (prog[k]) begin
            host_access(1'b1, 1'b0, 8'(k), prog[k]);
        end
    endtask

    task automatic start_core();
        halt_cycle = run_model();
        @(posedge sys_clk);
        #1;
        host_run = 1'b1;
    endtask

    task automatic wait_halted();
        while (!core_halted) begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic stop_core();
        @(posedge sys_clk);
        #1;
        host_run = 1'b0;
        while (core_halted) begin
            @(posedge sys_clk);
            #1;
        end
        @(posedge sys_clk);
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_errs) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d errors", name, err_cnt - test_errs);
        end
        test_errs = err_cnt;
    endtask

    initial begin
        logic [7:0]  addrs [$];
        logic [31:0] r;
        int          i;
        reset_i    = 1'b1;
        host_req   = '0;
        host_run   = 1'b0;
        exp_rdata  = '0;
        halt_cycle = MAX_CYCLES;
        repeat (16) @(posedge sys_clk);
        #1;
        reset_i = 1'b0;

        for (i = 0; i < N_RAND; i++) begin
            r = rand_word();
            addrs.push_back(r[7:0]);
            host_access(1'b1, 1'b0, r[7:0], rand_word());
            host_access(1'b1, 1'b1, r[7:0], rand_word());
        end
        foreach (addrs[k]) begin
            host_access(1'b0, 1'b0, addrs[k], '0);
            host_access(1'b0, 1'b1, addrs[k], '0);
        end
        end_test("1 host load and readback");

        for (i = 0; i < 8; i++) begin
            host_access(1'b1, 1'b1, 8'h40 + 8'(i), rand_word());
        end
        prog = {};
        prog.push_back(enc_mem(OP_LOAD, 8'h40));
        for (i = 1; i < 8; i++) begin
            prog.push_back(enc_mem(OP_ADD, 8'h40 + 8'(i)));
        end
        prog.push_back(enc_mem(OP_STORE, 8'h50));
        prog.push_back(enc_mem(OP_HALT, 8'h00));
        load_program();
        start_core();
        wait_halted();
        stop_core();
        host_access(1'b0, 1'b1, 8'h50, '0);
        end_test("2 summation program");

        host_access(1'b1, 1'b1, 8'h60, rand_word());
        prog = {enc_mem(OP_LOAD, 8'h60), enc_imm(OP_ADDI, 16'hFED4),
                enc_imm(OP_ADDI, 16'd1000), enc_imm(OP_ADDI, 16'h8000),
                enc_imm(OP_ADDI, 16'h7FFF), enc_imm(OP_ADDI, 16'hFFFF),
                enc_mem(OP_STORE, 8'h61), enc_mem(OP_HALT, 8'h00)};
        load_program();
        start_core();
        wait_halted();
        stop_core();
        host_access(1'b0, 1'b1, 8'h61, '0);
        end_test("3 immediates");

        // Counter at 0x71 climbs while the count at 0x70 falls to zero
        host_access(1'b1, 1'b1, 8'h70, 32'd5);
        host_access(1'b1, 1'b1, 8'h71, 32'd0);
        prog = {enc_mem(OP_LOAD, 8'h71), enc_imm(OP_ADDI, 16'd1), enc_mem(OP_STORE, 8'h71),
                enc_mem(OP_LOAD, 8'h70), enc_imm(OP_ADDI, 16'hFFFF),
                enc_mem(OP_STORE, 8'h70), enc_mem(OP_JNZ, 8'h00), enc_mem(OP_HALT, 8'h00)};
        load_program();
        start_core();
        wait_halted();
        stop_core();
        host_access(1'b0, 1'b1, 8'h71, '0);
        host_access(1'b0, 1'b1, 8'h70, '0);
        end_test("4 counting loop");

        host_access(1'b1, 1'b1, 8'h80, rand_word());
        host_access(1'b1, 1'b1, 8'h70, 32'd6);
        host_access(1'b1, 1'b1, 8'h71, 32'd0);
        start_core();                   // Same loop, still in imem
        repeat (20) @(posedge sys_clk);
        host_dropped_write(8'h80, rand_word());
        wait_halted();
        stop_core();
        host_access(1'b0, 1'b1, 8'h80, '0);
        host_access(1'b0, 1'b1, 8'h71, '0);
        host_access(1'b1, 1'b0, 8'hF0, rand_word());
        host_access(1'b0, 1'b0, 8'hF0, '0);
        end_test("5 dropped host request and reset control");

        $display("summary: %0d passed, %0d failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/procci_bus_pkg.sv
hw/procci_isa_pkg.sv
hw/wb_memory.sv
hw/controller.sv
hw/accum_core.sv
hw/processorci_top.sv
tb/tb_processorci_top.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, the result is judged from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_processorci_top -o sim_tb &&
out="$(./obj_dir/sim_tb)" &&
echo "$out" &&
echo "$out" | grep -qx "all tests passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
